/* common/upscale_cfg.svh */
`ifndef UPSCALE_CFG_SVH
`define UPSCALE_CFG_SVH

// bits per colour component
`define UPS_COMP_BITS 8

// pixels held per stored line
`define UPS_LINE_LEN 64

// lines in the buffer ring
`define UPS_LINE_CNT 16

// width counters and height counters
`define UPS_DIM_BITS 12

// step is in 1/64 of a source pixel
`define UPS_FRAC_BITS 6

`endif

/* common/upscale_pkg.sv */
`include "upscale_cfg.svh"

package upscale_pkg;

	// index widths into the line buffer ring
	localparam int line_bits = $clog2(`UPS_LINE_CNT);
	localparam int pix_bits  = $clog2(`UPS_LINE_LEN);

	typedef struct packed {
		logic [`UPS_COMP_BITS-1:0] red;
		logic [`UPS_COMP_BITS-1:0] green;
		logic [`UPS_COMP_BITS-1:0] blue;
	} pixel_t;

	// one video sample, syncs active low
	typedef struct packed {
		logic   hsync_n;
		logic   vsync_n;
		logic   active;
		pixel_t px;
	} vid_t;

	typedef struct packed {
		logic hsync_n;
		logic vsync_n;
		logic active;
	} timing_t;

	typedef struct packed {
		logic [`UPS_DIM_BITS-1:0] width;
		logic [`UPS_DIM_BITS-1:0] height;
	} dims_t;

	typedef struct packed {
		logic [`UPS_DIM_BITS+`UPS_FRAC_BITS-1:0] h;
		logic [`UPS_DIM_BITS+`UPS_FRAC_BITS-1:0] v;
	} step_t;

	typedef struct packed {
		logic [line_bits-1:0] line;
		logic [pix_bits-1:0]  pixel;
		logic                 valid;
	} src_addr_t;

endpackage

/* hw/frame_measure.sv */
`timescale 1ns/10ps
`include "upscale_cfg.svh"

module frame_measure import upscale_pkg::*; (
	input  logic    i_ClkB,
	input  logic    i_rst,
	input  timing_t i_timing,
	output dims_t   o_dims,
	output logic    o_locked
);

	logic                     hs_prev;
	logic                     vs_prev;
	logic                     line_edge;
	logic                     frame_edge;
	logic                     line_active;
	logic                     armed;
	logic [`UPS_DIM_BITS-1:0] pix_cnt;
	logic [`UPS_DIM_BITS-1:0] line_cnt;
	logic [`UPS_DIM_BITS-1:0] width_last;
	logic [`UPS_DIM_BITS-1:0] width_now;
	logic [`UPS_DIM_BITS-1:0] height_now;

	// falling sync edges
	assign line_edge   = hs_prev & ~i_timing.hsync_n;
	assign frame_edge  = vs_prev & ~i_timing.vsync_n;
	assign line_active = (pix_cnt != '0);

	// a line closing in the frame-edge cycle still counts for the old frame
	always_comb begin
		width_now  = width_last;
		height_now = line_cnt;
		if (line_edge && line_active) begin
			width_now  = pix_cnt;
			height_now = line_cnt + 1'b1;
		end
	end

	always_ff @(posedge i_ClkB) begin
		if (i_rst) begin
			hs_prev  <= 1'b1;
			vs_prev  <= 1'b1;
			pix_cnt  <= '0;
			line_cnt <= '0;
			armed    <= 1'b0;
			o_locked <= 1'b0;
		end else begin
			hs_prev <= i_timing.hsync_n;
			vs_prev <= i_timing.vsync_n;

			if (line_edge)
				pix_cnt <= `UPS_DIM_BITS'(i_timing.active);
			else if (i_timing.active)
				pix_cnt <= pix_cnt + 1'b1;

			if (frame_edge)
				line_cnt <= '0;
			else if (line_edge && line_active)
				line_cnt <= line_cnt + 1'b1;

			// first edge only arms, the second one locks
			if (frame_edge) begin
				armed <= 1'b1;
				if (armed)
					o_locked <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_ClkB) begin
		if (line_edge && line_active)
			width_last <= pix_cnt;
		// dims freeze once locked
		if (frame_edge && armed && !o_locked)
			o_dims <= '{width: width_now, height: height_now};
	end

endmodule

/* line_store/line_store.sv */
`timescale 1ns/10ps
`include "upscale_cfg.svh"

module line_store import upscale_pkg::*; (
	input  logic                 i_ClkB,
	input  logic                 i_rst,
	input  vid_t                 i_vid,
	input  src_addr_t            i_rd,
	output pixel_t               o_rd_px,
	output logic [line_bits-1:0] o_sof_line
);

	pixel_t mem [`UPS_LINE_CNT][`UPS_LINE_LEN];

	logic                 hs_prev;
	logic                 vs_prev;
	logic                 line_edge;
	logic                 frame_edge;
	logic                 line_used;
	logic [line_bits-1:0] wr_line;
	logic [line_bits-1:0] wr_line_next;
	logic [line_bits-1:0] frame_first;
	logic [pix_bits-1:0]  wr_pix;

	assign line_edge  = hs_prev & ~i_vid.hsync_n;
	assign frame_edge = vs_prev & ~i_vid.vsync_n;

	// ring advances only past lines that held video
	always_comb begin
		wr_line_next = wr_line;
		if (line_edge && line_used) begin
			if (wr_line == line_bits'(`UPS_LINE_CNT - 1))
				wr_line_next = '0;
			else
				wr_line_next = wr_line + 1'b1;
		end
	end

	always_ff @(posedge i_ClkB) begin
		if (i_rst) begin
			hs_prev     <= 1'b1;
			vs_prev     <= 1'b1;
			wr_line     <= '0;
			wr_pix      <= '0;
			line_used   <= 1'b0;
			frame_first <= '0;
			o_sof_line  <= '0;
		end else begin
			hs_prev <= i_vid.hsync_n;
			vs_prev <= i_vid.vsync_n;
			wr_line <= wr_line_next;

			if (line_edge) begin
				wr_pix    <= pix_bits'(i_vid.active);
				line_used <= i_vid.active;
			end else if (i_vid.active) begin
				wr_pix    <= wr_pix + 1'b1;
				line_used <= 1'b1;
			end

			// publish where the finished frame starts, remember the next start
			if (frame_edge) begin
				o_sof_line  <= frame_first;
				frame_first <= wr_line_next;
			end
		end
	end

	always_ff @(posedge i_ClkB) begin
		if (i_vid.active)
			mem[wr_line][wr_pix] <= i_vid.px;
		if (i_rd.valid)
			o_rd_px <= mem[i_rd.line][i_rd.pixel];
	end

endmodule

/* hw/scale_step.sv */
`timescale 1ns/10ps
`include "upscale_cfg.svh"

module scale_step import upscale_pkg::*; (
	input  logic  i_ClkB,
	input  logic  i_rst,
	input  logic  i_locked_in,
	input  logic  i_locked_out,
	input  dims_t i_dims_in,
	input  dims_t i_dims_out,
	output step_t o_step,
	output logic  o_step_valid
);

	localparam int q_bits   = `UPS_DIM_BITS + `UPS_FRAC_BITS;
	localparam int cnt_bits = $clog2(q_bits);

	typedef enum logic [1:0] {
		st_idle,
		st_div_h,
		st_div_v,
		st_done
	} state_t;

	state_t                   state;
	logic [cnt_bits-1:0]      bit_cnt;
	logic                     last_bit;
	logic [q_bits-1:0]        quo;
	logic [q_bits-1:0]        quo_next;
	logic [`UPS_DIM_BITS:0]   rem;
	logic [`UPS_DIM_BITS:0]   rem_next;
	logic [`UPS_DIM_BITS-1:0] divisor;
	logic [`UPS_DIM_BITS:0]   shifted;
	logic [`UPS_DIM_BITS+1:0] diff;

	// one restoring step per cycle
	assign shifted  = {rem[`UPS_DIM_BITS-1:0], quo[q_bits-1]};
	assign diff     = {1'b0, shifted} - {2'b00, divisor};
	assign quo_next = {quo[q_bits-2:0], ~diff[`UPS_DIM_BITS+1]};
	assign rem_next = diff[`UPS_DIM_BITS+1] ? shifted : diff[`UPS_DIM_BITS:0];
	assign last_bit = (bit_cnt == cnt_bits'(q_bits - 1));

	always_ff @(posedge i_ClkB) begin
		if (i_rst) begin
			state        <= st_idle;
			bit_cnt      <= '0;
			o_step_valid <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (i_locked_in && i_locked_out)
						state <= st_div_h;
				end
				st_div_h: begin
					if (last_bit)
						state <= st_div_v;
				end
				st_div_v: begin
					if (last_bit) begin
						state        <= st_done;
						o_step_valid <= 1'b1;
					end
				end
				default: begin
					state <= st_done;
				end
			endcase

			if (state == st_div_h || state == st_div_v)
				bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
		end
	end

	always_ff @(posedge i_ClkB) begin
		case (state)
			// width ratio operands, scaled by 64
			st_idle: begin
				quo     <= {i_dims_in.width, `UPS_FRAC_BITS'(0)};
				divisor <= i_dims_out.width;
				rem     <= '0;
			end
			st_div_h: begin
				if (last_bit) begin
					o_step.h <= quo_next;
					quo      <= {i_dims_in.height, `UPS_FRAC_BITS'(0)};
					divisor  <= i_dims_out.height;
					rem      <= '0;
				end else begin
					quo <= quo_next;
					rem <= rem_next;
				end
			end
			st_div_v: begin
				if (last_bit)
					o_step.v <= quo_next;
				quo <= quo_next;
				rem <= rem_next;
			end
			default: begin
				rem <= '0;
			end
		endcase
	end

endmodule

/* hw/source_addr.sv */
`timescale 1ns/10ps
`include "upscale_cfg.svh"

module source_addr import upscale_pkg::*; (
	input  logic                 i_ClkB,
	input  logic                 i_rst,
	input  timing_t              i_ref,
	input  step_t                i_step,
	input  logic                 i_step_valid,
	input  logic [line_bits-1:0] i_sof_line,
	output src_addr_t            o_addr,
	output timing_t              o_ref_d
);

	localparam int acc_bits = `UPS_DIM_BITS + `UPS_FRAC_BITS;

	logic                     hs_prev;
	logic                     vs_prev;
	logic                     line_edge;
	logic                     frame_edge;
	logic                     running;
	logic                     line_used;
	logic [acc_bits-1:0]      h_acc;
	logic [acc_bits-1:0]      v_acc;
	logic [`UPS_DIM_BITS-1:0] h_int;
	logic [`UPS_DIM_BITS-1:0] v_int;
	logic [`UPS_DIM_BITS-1:0] pix_mod;
	logic [`UPS_DIM_BITS:0]   line_sum;
	logic [`UPS_DIM_BITS:0]   line_mod;

	assign line_edge  = hs_prev & ~i_ref.hsync_n;
	assign frame_edge = vs_prev & ~i_ref.vsync_n;

	// integer parts of the source position
	assign h_int = h_acc[`UPS_FRAC_BITS +: `UPS_DIM_BITS];
	assign v_int = v_acc[`UPS_FRAC_BITS +: `UPS_DIM_BITS];

	assign pix_mod  = h_int % `UPS_DIM_BITS'(`UPS_LINE_LEN);
	assign line_sum = {1'b0, v_int} + {{(`UPS_DIM_BITS + 1 - line_bits){1'b0}}, i_sof_line};
	assign line_mod = line_sum % (`UPS_DIM_BITS + 1)'(`UPS_LINE_CNT);

	always_ff @(posedge i_ClkB) begin
		if (i_rst) begin
			hs_prev   <= 1'b1;
			vs_prev   <= 1'b1;
			running   <= 1'b0;
			line_used <= 1'b0;
			h_acc     <= '0;
			v_acc     <= '0;
			o_addr    <= '0;
			o_ref_d   <= '{hsync_n: 1'b1, vsync_n: 1'b1, active: 1'b0};
		end else begin
			hs_prev <= i_ref.hsync_n;
			vs_prev <= i_ref.vsync_n;

			// addressing begins on the first frame after the steps are known
			if (frame_edge && i_step_valid)
				running <= 1'b1;

			if (line_edge)
				h_acc <= '0;
			else if (i_ref.active)
				h_acc <= h_acc + i_step.h;

			if (line_edge)
				line_used <= i_ref.active;
			else if (i_ref.active)
				line_used <= 1'b1;

			if (frame_edge)
				v_acc <= '0;
			else if (line_edge && line_used)
				v_acc <= v_acc + i_step.v;

			o_addr.line  <= line_mod[line_bits-1:0];
			o_addr.pixel <= pix_mod[pix_bits-1:0];
			o_addr.valid <= running & i_ref.active;
			o_ref_d      <= i_ref;
		end
	end

endmodule

/* hw/upscaler_top.sv */
`timescale 1ns/10ps

module upscaler_top import upscale_pkg::*; (
	input  logic    i_ClkB,
	input  logic    i_rst,
	input  vid_t    i_vid,
	input  timing_t i_ref,
	output vid_t    o_vid,
	output dims_t   o_dims_in,
	output dims_t   o_dims_out,
	output logic    o_locked_in,
	output logic    o_locked_out,
	output step_t   o_step,
	output logic    o_step_valid
);

	timing_t              vid_timing;
	timing_t              ref_d1;
	timing_t              ref_d2;
	src_addr_t            rd_addr;
	logic                 rd_valid_d2;
	logic [line_bits-1:0] sof_line;
	pixel_t               rd_px;

	assign vid_timing = '{hsync_n: i_vid.hsync_n, vsync_n: i_vid.vsync_n, active: i_vid.active};

	frame_measure u_measure_in (
		.i_ClkB   (i_ClkB),
		.i_rst    (i_rst),
		.i_timing (vid_timing),
		.o_dims   (o_dims_in),
		.o_locked (o_locked_in)
	);

	frame_measure u_measure_out (
		.i_ClkB   (i_ClkB),
		.i_rst    (i_rst),
		.i_timing (i_ref),
		.o_dims   (o_dims_out),
		.o_locked (o_locked_out)
	);

	scale_step u_scale_step (
		.i_ClkB       (i_ClkB),
		.i_rst        (i_rst),
		.i_locked_in  (o_locked_in),
		.i_locked_out (o_locked_out),
		.i_dims_in    (o_dims_in),
		.i_dims_out   (o_dims_out),
		.o_step       (o_step),
		.o_step_valid (o_step_valid)
	);

	line_store u_line_store (
		.i_ClkB     (i_ClkB),
		.i_rst      (i_rst),
		.i_vid      (i_vid),
		.i_rd       (rd_addr),
		.o_rd_px    (rd_px),
		.o_sof_line (sof_line)
	);

	source_addr u_source_addr (
		.i_ClkB       (i_ClkB),
		.i_rst        (i_rst),
		.i_ref        (i_ref),
		.i_step       (o_step),
		.i_step_valid (o_step_valid),
		.i_sof_line   (sof_line),
		.o_addr       (rd_addr),
		.o_ref_d      (ref_d1)
	);

	// timing follows the buffer read, then the output register
	always_ff @(posedge i_ClkB) begin
		if (i_rst) begin
			ref_d2      <= '{hsync_n: 1'b1, vsync_n: 1'b1, active: 1'b0};
			rd_valid_d2 <= 1'b0;
			o_vid       <= '{hsync_n: 1'b1, vsync_n: 1'b1, active: 1'b0, px: '0};
		end else begin
			ref_d2        <= ref_d1;
			rd_valid_d2   <= rd_addr.valid;
			o_vid.hsync_n <= ref_d2.hsync_n;
			o_vid.vsync_n <= ref_d2.vsync_n;
			o_vid.active  <= ref_d2.active;
			// black outside active video and before addressing starts
			o_vid.px      <= (ref_d2.active && rd_valid_d2) ? rd_px : '0;
		end
	end

endmodule

/* bench/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// source pattern: red x, green y, blue x xor y
function automatic pixel_t pattern(input int x, input int y);
	pixel_t p;
	p.red   = `UPS_COMP_BITS'(x);
	p.green = `UPS_COMP_BITS'(y);
	p.blue  = `UPS_COMP_BITS'(x ^ y);
	return p;
endfunction

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

task automatic check_dims(input dims_t got, input dims_t exp, input string what);
	if (got !== exp) begin
		mismatches++;
		$display("MISMATCH at %0t: %s got %0dx%0d, expected %0dx%0d", $time, what,
			got.width, got.height, exp.width, exp.height);
	end
endtask

task automatic check_step(input step_t got, input step_t exp);
	if (got !== exp) begin
		mismatches++;
		$display("MISMATCH at %0t: step got h=%0d v=%0d, expected h=%0d v=%0d", $time,
			got.h, got.v, exp.h, exp.v);
	end
endtask

task automatic check_pixel(input pixel_t got, input pixel_t exp);
	if (got !== exp) begin
		mismatches++;
		$display("MISMATCH at %0t: pixel got %h, expected %h", $time, got, exp);
	end
endtask

task automatic check_timing(input timing_t got, input timing_t exp);
	if (got !== exp) begin
		mismatches++;
		$display("MISMATCH at %0t: timing got %b, expected %b", $time, got, exp);
	end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		mismatches++;
		$display("MISMATCH at %0t: %s got %b, expected %b", $time, what, got, exp);
	end
endtask

`endif

/* bench/tb_upscaler.sv */
`timescale 1ns/10ps
`include "upscale_cfg.svh"

module tb_upscaler import upscale_pkg::*; ();

	// largest raster is 32x16 plus blanking
	localparam int big_frame  = (32 + 4) * (16 + 2);
	localparam time watchdog_ns = (16 + 12 * big_frame) * 10;

	logic        i_ClkB;
	logic        i_rst;
	logic        rst_d;
	vid_t        vid;
	timing_t     ref_t;
	vid_t        o_vid;
	dims_t       o_dims_in;
	dims_t       o_dims_out;
	logic        o_locked_in;
	logic        o_locked_out;
	step_t       o_step;
	logic        o_step_valid;
	int          mismatches;
	int          other_errors;
	logic [31:0] lfsr_state;
	int          in_w, in_h, ref_w, ref_h;
	int          exp_h, exp_v;
	logic        gen_on, in_busy, ref_busy;
	// output-side model state
	timing_t     hist_t[$];
	pixel_t      hist_px[$];
	logic        m_hs_prev, m_vs_prev, m_used, started;
	int          m_i, m_j, frames_done;
	// frame boundaries seen on each stream since reset
	logic        in_vs_prev;
	int          in_frames;
	int          ref_frames;

	`include "tb_checks.svh"

	upscaler_top i_upscaler_top (
		.i_ClkB       (i_ClkB),
		.i_rst        (i_rst),
		.i_vid        (vid),
		.i_ref        (ref_t),
		.o_vid        (o_vid),
		.o_dims_in    (o_dims_in),
		.o_dims_out   (o_dims_out),
		.o_locked_in  (o_locked_in),
		.o_locked_out (o_locked_out),
		.o_step       (o_step),
		.o_step_valid (o_step_valid)
	);

	initial begin
		i_ClkB = 1'b0;
		forever #5 i_ClkB = ~i_ClkB;
	end

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int b = 0; b < n; b++) begin
			v = (v << 1) | int'(lfsr_state[31]);
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	task automatic gen_input_frame();
		for (int l = 0; l < in_h + 2; l++) begin
			for (int x = 0; x < in_w + 4; x++) begin
				@(posedge i_ClkB);
				#1;
				vid.active  = (l < in_h) && (x < in_w);
				vid.hsync_n = !(x == in_w + 1 || x == in_w + 2);
				vid.vsync_n = (l != in_h);
				vid.px      = vid.active ? pattern(x, l) : '0;
			end
		end
	endtask

	task automatic gen_ref_frame();
		for (int l = 0; l < ref_h + 2; l++) begin
			for (int x = 0; x < ref_w + 4; x++) begin
				@(posedge i_ClkB);
				#1;
				ref_t.active  = (l < ref_h) && (x < ref_w);
				ref_t.hsync_n = !(x == ref_w + 1 || x == ref_w + 2);
				ref_t.vsync_n = (l != ref_h);
			end
		end
	endtask

	initial begin
		fork
			forever begin
				wait (gen_on);
				in_busy = 1'b1;
				while (gen_on)
					gen_input_frame();
				@(posedge i_ClkB);
				#1;
				vid = '{hsync_n: 1'b1, vsync_n: 1'b1, active: 1'b0, px: '0};
				in_busy = 1'b0;
			end
			forever begin
				wait (gen_on);
				ref_busy = 1'b1;
				while (gen_on)
					gen_ref_frame();
				@(posedge i_ClkB);
				#1;
				ref_t = '{hsync_n: 1'b1, vsync_n: 1'b1, active: 1'b0};
				ref_busy = 1'b0;
			end
		join_none
	end

	// model of the output stream, compared 3 cycles later
	always @(negedge i_ClkB) begin : monitor
		logic    le;
		logic    fe;
		logic    in_fe;
		pixel_t  exp_px;
		timing_t got_t;
		timing_t idle_t;
		idle_t = '{hsync_n: 1'b1, vsync_n: 1'b1, active: 1'b0};
		got_t = '{hsync_n: o_vid.hsync_n, vsync_n: o_vid.vsync_n, active: o_vid.active};
		if (i_rst) begin
			if (rst_d) begin
				check_timing(got_t, idle_t);
				check_pixel(o_vid.px, '0);
				if (o_locked_in || o_locked_out || o_step_valid) begin
					other_errors++;
					$display("lock or step flag high during reset at %0t", $time);
				end
			end
			hist_t.delete();
			hist_px.delete();
			for (int k = 0; k < 3; k++) begin
				hist_t.push_back(idle_t);
				hist_px.push_back('0);
			end
			m_hs_prev = 1'b1;
			m_vs_prev = 1'b1;
			m_used    = 1'b0;
			m_i       = 0;
			m_j       = 0;
			started   = 1'b0;
			frames_done = 0;
			in_vs_prev = 1'b1;
			in_frames  = 0;
			ref_frames = 0;
		end else begin
			le = m_hs_prev & ~ref_t.hsync_n;
			fe = m_vs_prev & ~ref_t.vsync_n;
			in_fe = in_vs_prev & ~vid.vsync_n;
			// each lock rises the cycle after the second frame boundary of its stream
			check_flag(o_locked_in, in_frames >= 2, "input lock");
			check_flag(o_locked_out, ref_frames >= 2, "output lock");
			if (o_step_valid && !(o_locked_in && o_locked_out)) begin
				other_errors++;
				$display("step became valid before both sides locked at %0t", $time);
			end
			if (started && ref_t.active)
				exp_px = pattern((m_i * exp_h) >> 6, (m_j * exp_v) >> 6);
			else
				exp_px = '0;
			hist_t.push_back(ref_t);
			hist_px.push_back(exp_px);
			check_timing(got_t, hist_t.pop_front());
			check_pixel(o_vid.px, hist_px.pop_front());
			if (fe)
				m_j = 0;
			else if (le && m_used)
				m_j++;
			if (le) begin
				m_i    = 0;
				m_used = ref_t.active;
			end else if (ref_t.active) begin
				m_i++;
				m_used = 1'b1;
			end
			if (fe && started)
				frames_done++;
			if (fe && o_step_valid)
				started = 1'b1;
			if (fe)
				ref_frames++;
			if (in_fe)
				in_frames++;
			m_hs_prev = ref_t.hsync_n;
			m_vs_prev = ref_t.vsync_n;
			in_vs_prev = vid.vsync_n;
		end
		rst_d = i_rst;
	end

	task automatic wait_flag(input int which, input int limit);
		int n;
		logic f;
		n = 0;
		f = 1'b0;
		while (!f && n < limit) begin
			@(negedge i_ClkB);
			f = (which == 0) ? o_locked_in : (which == 1) ? o_locked_out : o_step_valid;
			n++;
		end
		if (!f) begin
			other_errors++;
			$display("flag %0d did not rise within %0d cycles", which, limit);
		end
	endtask

	task automatic wait_frames(input int count);
		int n;
		n = 0;
		while (frames_done < count && n < 4 * big_frame) begin
			@(negedge i_ClkB);
			n++;
		end
		if (frames_done < count) begin
			other_errors++;
			$display("output frames did not start after the step became valid");
		end
	endtask

	task automatic restart(input int iw, input int ih, input int rw, input int rh);
		gen_on = 1'b0;
		wait (!in_busy && !ref_busy);
		@(posedge i_ClkB);
		#1;
		i_rst = 1'b1;
		in_w  = iw;
		in_h  = ih;
		ref_w = rw;
		ref_h = rh;
		repeat (16) @(posedge i_ClkB);
		#1;
		i_rst = 1'b0;
		repeat (take_bits(4)) @(posedge i_ClkB);
		gen_on = 1'b1;
	endtask

	task automatic test_input_measure(input int w, input int h);
		wait_flag(0, 4 * big_frame);
		check_dims(o_dims_in, '{width: 12'(w), height: 12'(h)}, "input dims");
	endtask

	task automatic test_output_and_step(input int w, input int h, input int step);
		wait_flag(1, 4 * big_frame);
		check_dims(o_dims_out, '{width: 12'(w), height: 12'(h)}, "output dims");
		wait_flag(2, 100);
		check_step(o_step, '{h: 18'(step), v: 18'(step)});
	endtask

	task automatic test_upscale(input int step);
		exp_h = step;
		exp_v = step;
		// one whole output frame is compared
		wait_frames(1);
		if (o_locked_in !== 1'b1 || o_locked_out !== 1'b1 || o_step_valid !== 1'b1) begin
			other_errors++;
			$display("a lock or step flag dropped after locking");
		end
	endtask

	initial begin
		i_rst        = 1'b1;
		rst_d        = 1'b0;
		vid          = '{hsync_n: 1'b1, vsync_n: 1'b1, active: 1'b0, px: '0};
		ref_t        = '{hsync_n: 1'b1, vsync_n: 1'b1, active: 1'b0};
		gen_on       = 1'b0;
		in_busy      = 1'b0;
		ref_busy     = 1'b0;
		mismatches   = 0;
		other_errors = 0;
		lfsr_state   = 32'hae84_e26e;
		exp_h        = 32;
		exp_v        = 32;
		restart(16, 8, 32, 16);
		test_input_measure(16, 8);
		test_output_and_step(32, 16, 32);
		test_upscale(32);
		// non-integer ratio, 64*12/20 rounds down
		restart(12, 6, 20, 10);
		test_input_measure(12, 6);
		test_output_and_step(20, 10, 38);
		test_upscale(38);
		$display("mismatches: %0d, other errors: %0d", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("the run timed out after %0t", $time);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* files.f */
+incdir+common
+incdir+bench
common/upscale_pkg.sv
hw/frame_measure.sv
line_store/line_store.sv
hw/scale_step.sv
hw/source_addr.sv
hw/upscaler_top.sv
bench/tb_upscaler.sv

/* run_sim.sh */
#!/bin/sh
# build and run the upscaler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_upscaler -o sim_upscaler
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_upscaler > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed"
exit 1
